//--- src/mmio_config.svh
`ifndef MMIO_CONFIG_SVH
`define MMIO_CONFIG_SVH

// bus widths
`define MMIO_ADDR_W       32
`define MMIO_DATA_W       32

// peripheral widths and sizes
`define FB_ADDR_W         20
`define LINE_COORD_W      10
`define TONE_PERIOD_W     24
`define TONE_PERIOD_RST   24'h555
`define SAMPLE_W          24
`define BTN_FIFO_DEPTH    8

// top address nibble of each region
`define REGION_MMIO       4'h8
`define REGION_FB         4'h9

// ----------------------------------------
// register offsets inside the mmio region
// ----------------------------------------
`define ADDR_CYCLE_CNT    28'h000_0010
`define ADDR_CNT_CLEAR    28'h000_0018
`define ADDR_BTN_EMPTY    28'h000_0020
`define ADDR_BTN_DATA     28'h000_0024
`define ADDR_SWITCHES     28'h000_0028
`define ADDR_LEDS         28'h000_0030
`define ADDR_TONE_EN      28'h000_0034
`define ADDR_TONE_PERIOD  28'h000_0038
`define ADDR_SAMPLE_FULL  28'h000_0040
`define ADDR_SAMPLE_DATA  28'h000_0044
`define ADDR_LINE_X0      28'h001_0000
`define ADDR_LINE_X1      28'h001_0004
`define ADDR_LINE_Y0      28'h001_0008
`define ADDR_LINE_Y1      28'h001_000C
`define ADDR_LINE_COLOR   28'h001_0010
`define ADDR_LINE_FIRE    28'h001_0014

`endif

//--- src/mmio_pkg.sv
`include "mmio_config.svh"

package mmio_pkg;

    // one bus address, seen as a register or as a pixel
    typedef union packed {
        struct packed {
            logic [3:0]                 region;
            logic [`MMIO_ADDR_W-5:0]    offset;
        } reg_view;
        struct packed {
            logic [3:0]                             region;
            logic [`MMIO_ADDR_W-5-`FB_ADDR_W:0]     unused;
            logic [`FB_ADDR_W-1:0]                  index;
        } fb_view;
    } mmio_addr_u;

    // decoded register select
    typedef enum logic [4:0] {
        sel_cycle_cnt,
        sel_cnt_clear,
        sel_btn_empty,
        sel_btn_data,
        sel_switches,
        sel_leds,
        sel_tone_en,
        sel_tone_period,
        sel_sample_full,
        sel_sample_data,
        sel_line_x0,
        sel_line_x1,
        sel_line_y0,
        sel_line_y1,
        sel_line_color,
        sel_line_fire,
        sel_fb_pixel,
        sel_unmapped
    } mmio_reg_e;

endpackage

//--- src/apb_mmio_ctrl.sv
`timescale 1ns/10ps
`include "mmio_config.svh"

module apb_mmio_ctrl import mmio_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  mmio_addr_u                  paddr,
    input  logic [`MMIO_DATA_W-1:0]     pwdata,
    input  logic [`MMIO_DATA_W-1:0]     cycle_cnt,
    input  logic                        btn_empty,
    input  logic [3:0]                  btn_data,
    input  logic [1:0]                  switches,
    input  logic [5:0]                  leds_val,
    input  logic                        tone_en_val,
    input  logic [`TONE_PERIOD_W-1:0]   tone_period_val,
    input  logic                        sample_full,
    input  logic [`LINE_COORD_W-1:0]    x0_val,
    input  logic [`LINE_COORD_W-1:0]    x1_val,
    input  logic [`LINE_COORD_W-1:0]    y0_val,
    input  logic [`LINE_COORD_W-1:0]    y1_val,
    input  logic                        color_val,
    output logic [`MMIO_DATA_W-1:0]     prdata,
    output logic                        pready,
    output logic                        pslverr,
    output mmio_reg_e                   wr_sel,
    output logic                        wr_stb,
    output logic                        rd_pop,
    output logic [`MMIO_DATA_W-1:0]     wdata
);

    logic access;   // completing cycle of a transfer
    logic mapped;
    logic psel_q;

    assign access  = psel && penable;
    assign mapped  = (wr_sel != sel_unmapped);
    assign pready  = access;                   // zero wait states
    assign pslverr = access && !mapped;
    assign wr_stb  = access && pwrite && mapped;
    assign rd_pop  = access && !pwrite && (wr_sel == sel_btn_data);
    assign wdata   = pwdata;

    // ----------------------------------------
    // address decode
    // ----------------------------------------
    always_comb begin
        wr_sel = sel_unmapped;
        if (paddr.reg_view.region == `REGION_FB) begin
            wr_sel = sel_fb_pixel;
        end else if (paddr.reg_view.region == `REGION_MMIO) begin
            case (paddr.reg_view.offset)
                `ADDR_CYCLE_CNT:   wr_sel = sel_cycle_cnt;
                `ADDR_CNT_CLEAR:   wr_sel = sel_cnt_clear;
                `ADDR_BTN_EMPTY:   wr_sel = sel_btn_empty;
                `ADDR_BTN_DATA:    wr_sel = sel_btn_data;
                `ADDR_SWITCHES:    wr_sel = sel_switches;
                `ADDR_LEDS:        wr_sel = sel_leds;
                `ADDR_TONE_EN:     wr_sel = sel_tone_en;
                `ADDR_TONE_PERIOD: wr_sel = sel_tone_period;
                `ADDR_SAMPLE_FULL: wr_sel = sel_sample_full;
                `ADDR_SAMPLE_DATA: wr_sel = sel_sample_data;
                `ADDR_LINE_X0:     wr_sel = sel_line_x0;
                `ADDR_LINE_X1:     wr_sel = sel_line_x1;
                `ADDR_LINE_Y0:     wr_sel = sel_line_y0;
                `ADDR_LINE_Y1:     wr_sel = sel_line_y1;
                `ADDR_LINE_COLOR:  wr_sel = sel_line_color;
                `ADDR_LINE_FIRE:   wr_sel = sel_line_fire;
                default:           wr_sel = sel_unmapped;
            endcase
        end
    end

    // read mux, write-only and unmapped read as zero
    always_comb begin
        prdata = '0;
        case (wr_sel)
            sel_cycle_cnt:   prdata = cycle_cnt;
            sel_btn_empty:   prdata[0] = btn_empty;
            sel_btn_data:    prdata[3:0] = btn_data;
            sel_switches:    prdata[1:0] = switches;
            sel_leds:        prdata[5:0] = leds_val;
            sel_tone_en:     prdata[0] = tone_en_val;
            sel_tone_period: prdata[`TONE_PERIOD_W-1:0] = tone_period_val;
            sel_sample_full: prdata[0] = sample_full;
            sel_line_x0:     prdata[`LINE_COORD_W-1:0] = x0_val;
            sel_line_x1:     prdata[`LINE_COORD_W-1:0] = x1_val;
            sel_line_y0:     prdata[`LINE_COORD_W-1:0] = y0_val;
            sel_line_y1:     prdata[`LINE_COORD_W-1:0] = y1_val;
            sel_line_color:  prdata[0] = color_val;
            default:         prdata = '0;
        endcase
    end

    // setup phase tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            psel_q <= 1'b0;
        end else begin
            psel_q <= psel;
        end
    end

    // access phase must follow a setup phase
    assert property (@(posedge clk) disable iff (rst) $rose(penable) |-> psel_q)
        else $error("penable rose without a setup cycle");

endmodule

//--- src/button_fifo.sv
`timescale 1ns/10ps
`include "mmio_config.svh"

module button_fifo import mmio_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  buttons,
    input  logic        pop,
    output logic        empty,
    output logic [3:0]  data
);

    localparam int PTR_W = $clog2(`BTN_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`BTN_FIFO_DEPTH + 1);

    logic [3:0]       mem [`BTN_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [3:0]       cap_q;    // captured pattern, pushed next cycle
    logic             cap_vld;
    logic             room;
    logic             do_pop;

    assign empty  = (count == '0);
    assign do_pop = pop && !empty;         // pop on empty ignored
    // leave space for a capture already in flight
    assign room   = (count + CNT_W'(cap_vld)) < CNT_W'(`BTN_FIFO_DEPTH);
    assign data   = empty ? 4'h0 : mem[rd_ptr];

    // ----------------------------------------
    // capture stage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            cap_vld <= 1'b0;
        end else begin
            cap_vld <= (|buttons) && room;
        end
    end

    always_ff @(posedge clk) begin
        if ((|buttons) && room) cap_q <= buttons;
        if (cap_vld) mem[wr_ptr] <= cap_q;
    end

    // pointers and fill level
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (cap_vld) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({cap_vld, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        cap_vld |-> count < CNT_W'(`BTN_FIFO_DEPTH))
        else $error("button FIFO push while full");

    assert property (@(posedge clk) disable iff (rst)
        count <= CNT_W'(`BTN_FIFO_DEPTH))
        else $error("button FIFO count above depth");

endmodule

//--- src/board_io_regs.sv
`timescale 1ns/10ps
`include "mmio_config.svh"

module board_io_regs import mmio_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  mmio_reg_e                   wr_sel,
    input  logic                        wr_stb,
    input  logic [`MMIO_DATA_W-1:0]     wdata,
    output logic [`MMIO_DATA_W-1:0]     cycle_cnt,
    output logic [5:0]                  leds,
    output logic [7:0]                  pmod_leds,
    output logic                        tone_output_enable,
    output logic [`TONE_PERIOD_W-1:0]   tone_switch_period,
    output logic [`SAMPLE_W-1:0]        sample_din,
    output logic                        sample_wr_en
);

    logic sample_wr;

    assign sample_wr = wr_stb && (wr_sel == sel_sample_data);

    // free running, cleared by a write to cnt_clear
    always_ff @(posedge clk) begin
        if (rst || (wr_stb && wr_sel == sel_cnt_clear)) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // leds and tone generator
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            leds               <= '0;
            pmod_leds          <= '0;
            tone_output_enable <= 1'b0;
            tone_switch_period <= `TONE_PERIOD_RST;
        end else if (wr_stb) begin
            case (wr_sel)
                sel_leds: begin
                    leds      <= wdata[5:0];
                    pmod_leds <= wdata[15:8];
                end
                sel_tone_en:     tone_output_enable <= wdata[0];
                sel_tone_period: tone_switch_period <= wdata[`TONE_PERIOD_W-1:0];
                default: ;
            endcase
        end
    end

    // audio sample push, full flag is left to software
    always_ff @(posedge clk) begin
        if (rst) begin
            sample_wr_en <= 1'b0;
        end else begin
            sample_wr_en <= sample_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (sample_wr) sample_din <= wdata[`SAMPLE_W-1:0];
    end

    assert property (@(posedge clk) disable iff (rst)
        sample_wr_en && $past(sample_wr_en) |-> $past(sample_wr))
        else $error("sample_wr_en held without a new sample write");

endmodule

//--- src/video_draw_regs.sv
`timescale 1ns/10ps
`include "mmio_config.svh"

module video_draw_regs import mmio_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  mmio_reg_e                   wr_sel,
    input  logic                        wr_stb,
    input  logic [`MMIO_DATA_W-1:0]     wdata,
    input  logic [`FB_ADDR_W-1:0]       fb_index,
    input  logic                        hdmi_rx_ready,
    output logic                        fb_we,
    output logic [`FB_ADDR_W-1:0]       fb_addr,
    output logic                        fb_data,
    output logic [`LINE_COORD_W-1:0]    x0,
    output logic [`LINE_COORD_W-1:0]    x1,
    output logic [`LINE_COORD_W-1:0]    y0,
    output logic [`LINE_COORD_W-1:0]    y1,
    output logic                        color,
    output logic                        hdmi_rx_valid
);

    logic pix_wr;

    assign pix_wr = wr_stb && (wr_sel == sel_fb_pixel);

    // ----------------------------------------
    // framebuffer pixel port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            fb_we <= 1'b0;
        end else begin
            fb_we <= pix_wr;    // one cycle per pixel write
        end
    end

    always_ff @(posedge clk) begin
        if (pix_wr) begin
            fb_addr <= fb_index;
            fb_data <= wdata[0];   // 1 bit per pixel
        end
    end

    // line endpoints, color and fire
    always_ff @(posedge clk) begin
        if (rst) begin
            x0            <= '0;
            x1            <= '0;
            y0            <= '0;
            y1            <= '0;
            color         <= 1'b0;
            hdmi_rx_valid <= 1'b0;
        end else begin
            // fire dropped if the engine is busy
            hdmi_rx_valid <= wr_stb && (wr_sel == sel_line_fire) && hdmi_rx_ready;
            if (wr_stb) begin
                case (wr_sel)
                    sel_line_x0:    x0 <= wdata[`LINE_COORD_W-1:0];
                    sel_line_x1:    x1 <= wdata[`LINE_COORD_W-1:0];
                    sel_line_y0:    y0 <= wdata[`LINE_COORD_W-1:0];
                    sel_line_y1:    y1 <= wdata[`LINE_COORD_W-1:0];
                    sel_line_color: color <= wdata[0];
                    default: ;
                endcase
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        hdmi_rx_valid |-> $past(hdmi_rx_ready))
        else $error("hdmi_rx_valid without ready in the previous cycle");

endmodule

//--- src/mmio_top.sv
`timescale 1ns/10ps
`include "mmio_config.svh"

module mmio_top import mmio_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    // apb slave
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  mmio_addr_u                  paddr,
    input  logic [`MMIO_DATA_W-1:0]     pwdata,
    output logic [`MMIO_DATA_W-1:0]     prdata,
    output logic                        pready,
    output logic                        pslverr,
    // board io
    input  logic [3:0]                  buttons,
    input  logic [1:0]                  switches,
    output logic [5:0]                  leds,
    output logic [7:0]                  pmod_leds,
    output logic                        tone_output_enable,
    output logic [`TONE_PERIOD_W-1:0]   tone_switch_period,
    output logic [`SAMPLE_W-1:0]        sample_din,
    output logic                        sample_wr_en,
    input  logic                        async_fifo_full,
    // video
    output logic                        fb_we,
    output logic [`FB_ADDR_W-1:0]       fb_addr,
    output logic                        fb_data,
    output logic [`LINE_COORD_W-1:0]    x0,
    output logic [`LINE_COORD_W-1:0]    x1,
    output logic [`LINE_COORD_W-1:0]    y0,
    output logic [`LINE_COORD_W-1:0]    y1,
    output logic                        color,
    output logic                        hdmi_rx_valid,
    input  logic                        hdmi_rx_ready
);

    mmio_reg_e                  wr_sel;
    logic                       wr_stb;
    logic                       rd_pop;
    logic [`MMIO_DATA_W-1:0]    wdata;
    logic [`MMIO_DATA_W-1:0]    cycle_cnt;
    logic                       btn_empty;
    logic [3:0]                 btn_data;

    apb_mmio_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .cycle_cnt(cycle_cnt),
        .btn_empty(btn_empty), .btn_data(btn_data),
        .switches(switches),
        .leds_val(leds),
        .tone_en_val(tone_output_enable),
        .tone_period_val(tone_switch_period),
        .sample_full(async_fifo_full),
        .x0_val(x0), .x1_val(x1), .y0_val(y0), .y1_val(y1),
        .color_val(color),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .wr_sel(wr_sel), .wr_stb(wr_stb), .rd_pop(rd_pop), .wdata(wdata)
    );

    button_fifo u_btn_fifo (
        .clk(clk), .rst(rst),
        .buttons(buttons), .pop(rd_pop),
        .empty(btn_empty), .data(btn_data)
    );

    board_io_regs u_board_io (
        .clk(clk), .rst(rst),
        .wr_sel(wr_sel), .wr_stb(wr_stb), .wdata(wdata),
        .cycle_cnt(cycle_cnt),
        .leds(leds), .pmod_leds(pmod_leds),
        .tone_output_enable(tone_output_enable),
        .tone_switch_period(tone_switch_period),
        .sample_din(sample_din), .sample_wr_en(sample_wr_en)
    );

    // pixel index straight from the framebuffer view of the address
    video_draw_regs u_video (
        .clk(clk), .rst(rst),
        .wr_sel(wr_sel), .wr_stb(wr_stb), .wdata(wdata),
        .fb_index(paddr.fb_view.index),
        .hdmi_rx_ready(hdmi_rx_ready),
        .fb_we(fb_we), .fb_addr(fb_addr), .fb_data(fb_data),
        .x0(x0), .x1(x1), .y0(y0), .y1(y1), .color(color),
        .hdmi_rx_valid(hdmi_rx_valid)
    );

endmodule

//--- tb/tb_mmio_top.sv
`timescale 1ns/10ps
`include "mmio_config.svh"

module tb_mmio_top;

    localparam int N_RANDOM = 3;
    // roughly 100 transfers of 4 to 5 clocks plus the button fill, with wide margin
    localparam int WATCHDOG_CYCLES = 2000;
    localparam logic [31:0] COORD_MASK = (32'h1 << `LINE_COORD_W) - 32'h1;
    localparam logic [27:0] LINE_OFFS [5] = '{`ADDR_LINE_X0, `ADDR_LINE_X1,
        `ADDR_LINE_Y0, `ADDR_LINE_Y1, `ADDR_LINE_COLOR};
    localparam logic [31:0] LINE_MASKS [5] = '{COORD_MASK, COORD_MASK,
        COORD_MASK, COORD_MASK, 32'h1};

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`MMIO_ADDR_W-1:0]    paddr;
    logic [`MMIO_DATA_W-1:0]    pwdata;
    logic [`MMIO_DATA_W-1:0]    prdata;
    logic                       pready;
    logic                       pslverr;
    logic [3:0]                 buttons;
    logic [1:0]                 switches;
    logic [5:0]                 leds;
    logic [7:0]                 pmod_leds;
    logic                       tone_output_enable;
    logic [`TONE_PERIOD_W-1:0]  tone_switch_period;
    logic [`SAMPLE_W-1:0]       sample_din;
    logic                       sample_wr_en;
    logic                       async_fifo_full;
    logic                       fb_we;
    logic [`FB_ADDR_W-1:0]      fb_addr;
    logic                       fb_data;
    logic [`LINE_COORD_W-1:0]   x0;
    logic [`LINE_COORD_W-1:0]   x1;
    logic [`LINE_COORD_W-1:0]   y0;
    logic [`LINE_COORD_W-1:0]   y1;
    logic                       color;
    logic                       hdmi_rx_valid;
    logic                       hdmi_rx_ready;

    integer         seed;
    int             clk_count = 0;
    logic [31:0]    last_rdata;     // prdata of the latest transfer
    logic           last_err;
    int             last_clk;       // clk_count when it was sampled

    mmio_top u_dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) clk_count <= clk_count + 1;

    // ----------------------------------------
    // failure reporting and checks
    // ----------------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("CHECK FAILED: %s expected 0x%0h actual 0x%0h", name, exp, act);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else report_mismatch(name, exp, act);
    endtask

    function automatic logic [31:0] mmio_addr(input logic [27:0] off);
        return {`REGION_MMIO, off};
    endfunction

    // ----------------------------------------
    // apb master
    // ----------------------------------------
    task automatic apb_access(input logic write, input logic [31:0] addr,
                              input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;    // setup
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;    // access
        do @(negedge clk); while (!pready);
        last_rdata = prdata;
        last_err   = pslverr;
        last_clk   = clk_count;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        apb_access(1'b1, addr, data);
    endtask

    task automatic apb_read(input logic [31:0] addr);
        apb_access(1'b0, addr, 32'h0);
    endtask

    task automatic check_read(input string name, input logic [31:0] addr,
                              input logic [31:0] exp);
        apb_read(addr);
        check_value(name, exp, last_rdata);
        check_value({name, " pslverr"}, 32'h0, 32'(last_err));
    endtask

    // write, look at the output one clock later, then read back
    task automatic reg_roundtrip(input string name, input logic [27:0] off,
                                 input logic [31:0] data, input logic [31:0] rd_mask,
                                 input logic [31:0] out_mask);
        logic [31:0] seen;
        apb_write(mmio_addr(off), data);
        check_value({name, " write pslverr"}, 32'h0, 32'(last_err));
        @(negedge clk);
        case (off)
            `ADDR_LEDS:        seen = {16'h0, pmod_leds, 2'b00, leds};
            `ADDR_TONE_EN:     seen = 32'(tone_output_enable);
            `ADDR_TONE_PERIOD: seen = 32'(tone_switch_period);
            `ADDR_LINE_X0:     seen = 32'(x0);
            `ADDR_LINE_X1:     seen = 32'(x1);
            `ADDR_LINE_Y0:     seen = 32'(y0);
            `ADDR_LINE_Y1:     seen = 32'(y1);
            `ADDR_LINE_COLOR:  seen = 32'(color);
            default:           seen = 32'h0;
        endcase
        check_value({name, " output"}, data & out_mask, seen);
        check_read({name, " readback"}, mmio_addr(off), data & rd_mask);
    endtask

    // bus timing and one-cycle pulses
    assert property (@(posedge clk) disable iff (rst) pready == (psel && penable))
        else report_failure("pready does not follow the APB access phase");
    assert property (@(posedge clk) disable iff (rst) pslverr |-> pready)
        else report_failure("pslverr raised outside an access cycle");
    assert property (@(posedge clk) disable iff (rst) fb_we |=> !fb_we)
        else report_failure("fb_we stayed high for more than one cycle");
    assert property (@(posedge clk) disable iff (rst) sample_wr_en |=> !sample_wr_en)
        else report_failure("sample_wr_en stayed high for more than one cycle");
    assert property (@(posedge clk) disable iff (rst) hdmi_rx_valid |=> !hdmi_rx_valid)
        else report_failure("hdmi_rx_valid stayed high for more than one cycle");

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure("watchdog expired before the tests finished");
    end

    initial begin
        logic [31:0] data;
        logic [31:0] addr;
        logic [31:0] c1;
        logic [3:0]  pattern;
        int          k1;
        int          pops;
        int          mark;

        seed = 32'h9997_1868;
        rst             <= 1'b1;
        psel            <= 1'b0;
        penable         <= 1'b0;
        pwrite          <= 1'b0;
        paddr           <= 32'h0;
        pwdata          <= 32'h0;
        buttons         <= 4'h0;
        switches        <= 2'b00;
        async_fifo_full <= 1'b0;
        hdmi_rx_ready   <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        // ----------------------------------------
        // reset values
        // ----------------------------------------
        check_value("reset leds", 32'h0, {16'h0, pmod_leds, 2'b00, leds});
        check_value("reset tone enable", 32'h0, 32'(tone_output_enable));
        check_value("reset tone period", 32'h555, 32'(tone_switch_period));
        check_value("reset pulses", 32'h0,
            32'({sample_wr_en, fb_we, hdmi_rx_valid, pready, pslverr}));
        check_value("reset line x", 32'h0, 32'({x0, x1}));
        check_value("reset line y", 32'h0, 32'({y0, y1, color}));
        mark = clk_count;   // counter starts from zero at this clock
        apb_read(mmio_addr(`ADDR_CYCLE_CNT));
        check_value("reset cycle count", 32'(last_clk - mark), last_rdata);
        check_read("reset tone period read", mmio_addr(`ADDR_TONE_PERIOD), 32'h555);
        check_read("reset leds read", mmio_addr(`ADDR_LEDS), 32'h0);
        check_read("reset tone enable read", mmio_addr(`ADDR_TONE_EN), 32'h0);
        check_read("reset btn empty", mmio_addr(`ADDR_BTN_EMPTY), 32'h1);
        check_read("reset btn data", mmio_addr(`ADDR_BTN_DATA), 32'h0);
        check_read("reset sample full", mmio_addr(`ADDR_SAMPLE_FULL), 32'h0);
        for (int j = 0; j < 5; j++) begin
            check_read($sformatf("reset line reg %0d", j), mmio_addr(LINE_OFFS[j]), 32'h0);
        end
        // write-only registers read as zero
        check_read("read cnt_clear", mmio_addr(`ADDR_CNT_CLEAR), 32'h0);
        check_read("read sample_data", mmio_addr(`ADDR_SAMPLE_DATA), 32'h0);
        check_read("read line_fire", mmio_addr(`ADDR_LINE_FIRE), 32'h0);
        check_read("read fb pixel", {`REGION_FB, 28'h000_0040}, 32'h0);

        // random register traffic
        for (int i = 0; i < N_RANDOM; i++) begin
            data = $random(seed);
            reg_roundtrip("leds", `ADDR_LEDS, data, 32'h3F, 32'hFF3F);
            data = $random(seed);
            reg_roundtrip("tone enable", `ADDR_TONE_EN, data, 32'h1, 32'h1);
            data = $random(seed);
            reg_roundtrip("tone period", `ADDR_TONE_PERIOD, data, 32'hFF_FFFF, 32'hFF_FFFF);
            for (int j = 0; j < 5; j++) begin
                data = $random(seed);
                reg_roundtrip($sformatf("line reg %0d", j), LINE_OFFS[j], data,
                    LINE_MASKS[j], LINE_MASKS[j]);
            end
        end

        // ----------------------------------------
        // framebuffer and audio sample
        // ----------------------------------------
        addr = $random(seed);
        addr[31:28] = `REGION_FB;
        data = $random(seed);
        apb_write(addr, data);
        check_value("fb write pslverr", 32'h0, 32'(last_err));
        @(negedge clk);
        check_value("fb_we pulse", 32'h1, 32'(fb_we));
        check_value("fb_addr", 32'(addr[`FB_ADDR_W-1:0]), 32'(fb_addr));
        check_value("fb_data", 32'(data[0]), 32'(fb_data));
        @(negedge clk);
        check_value("fb_we after pulse", 32'h0, 32'(fb_we));

        data = $random(seed);
        apb_write(mmio_addr(`ADDR_SAMPLE_DATA), data);
        @(negedge clk);
        check_value("sample_wr_en pulse", 32'h1, 32'(sample_wr_en));
        check_value("sample_din", data & 32'hFF_FFFF, 32'(sample_din));
        @(negedge clk);
        check_value("sample_wr_en after pulse", 32'h0, 32'(sample_wr_en));
        @(posedge clk);
        async_fifo_full <= 1'b1;
        check_read("sample full set", mmio_addr(`ADDR_SAMPLE_FULL), 32'h1);
        @(posedge clk);
        async_fifo_full <= 1'b0;
        check_read("sample full clear", mmio_addr(`ADDR_SAMPLE_FULL), 32'h0);

        // line fire, taken only while the engine is ready
        @(posedge clk);
        hdmi_rx_ready <= 1'b1;
        apb_write(mmio_addr(`ADDR_LINE_FIRE), 32'h1);
        @(negedge clk);
        check_value("fire with ready", 32'h1, 32'(hdmi_rx_valid));
        @(posedge clk);
        hdmi_rx_ready <= 1'b0;
        apb_write(mmio_addr(`ADDR_LINE_FIRE), 32'h1);
        @(negedge clk);
        check_value("fire without ready", 32'h0, 32'(hdmi_rx_valid));
        @(negedge clk);
        check_value("fire without ready later", 32'h0, 32'(hdmi_rx_valid));

        // ----------------------------------------
        // buttons and switches
        // ----------------------------------------
        pattern = 4'($random(seed));
        if (pattern == 4'h0) pattern = 4'h5;
        @(posedge clk);
        buttons <= pattern;
        repeat (`BTN_FIFO_DEPTH + 4) @(posedge clk);  // one entry per clock
        buttons <= 4'h0;
        check_read("btn not empty", mmio_addr(`ADDR_BTN_EMPTY), 32'h0);
        pops = 0;
        apb_read(mmio_addr(`ADDR_BTN_EMPTY));
        while (last_rdata[0] == 1'b0 && pops < `BTN_FIFO_DEPTH + 2) begin
            check_read("btn data", mmio_addr(`ADDR_BTN_DATA), 32'(pattern));
            pops++;
            apb_read(mmio_addr(`ADDR_BTN_EMPTY));
        end
        check_value("btn entries", 32'(`BTN_FIFO_DEPTH), 32'(pops));
        check_read("btn data when empty", mmio_addr(`ADDR_BTN_DATA), 32'h0);
        check_read("btn empty again", mmio_addr(`ADDR_BTN_EMPTY), 32'h1);

        data = $random(seed);
        @(posedge clk);
        switches <= data[1:0];
        check_read("switches", mmio_addr(`ADDR_SWITCHES), 32'(data[1:0]));

        // counter runs one per clock, clear reads zero a clock later
        apb_read(mmio_addr(`ADDR_CYCLE_CNT));
        c1 = last_rdata;
        k1 = last_clk;
        repeat (3) apb_read(mmio_addr(`ADDR_SWITCHES));
        apb_read(mmio_addr(`ADDR_CYCLE_CNT));
        check_value("counter advanced", 32'h1, 32'(last_rdata > c1));
        check_value("counter delta", 32'(last_clk - k1), last_rdata - c1);
        apb_write(mmio_addr(`ADDR_CNT_CLEAR), 32'h0);
        @(negedge clk);
        mark = clk_count;
        apb_read(mmio_addr(`ADDR_CYCLE_CNT));
        check_value("counter after clear", 32'(last_clk - mark), last_rdata);

        // unmapped accesses
        apb_read(mmio_addr(28'h000_0050));
        check_value("unmapped read pslverr", 32'h1, 32'(last_err));
        check_value("unmapped read data", 32'h0, last_rdata);
        data = $random(seed);
        apb_write(mmio_addr(`ADDR_LEDS), data);
        apb_write({4'h3, 28'h000_0030}, ~data);    // led offset in a dead region
        check_value("unmapped write pslverr", 32'h1, 32'(last_err));
        @(negedge clk);
        check_value("unmapped write ignored", data & 32'hFF3F,
            {16'h0, pmod_leds, 2'b00, leds});

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+src
src/mmio_pkg.sv
src/apb_mmio_ctrl.sv
src/button_fifo.sv
src/board_io_regs.sv
src/video_draw_regs.sv
src/mmio_top.sv
tb/tb_mmio_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mmio testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_mmio_top -Mdir obj_dir -o sim_tb_mmio_top \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_mmio_top
if [ $? -ne 0 ]; then
    echo "simulation run failed"
    exit 1
fi
exit 0
